/* hdl/efpga_pkg.sv */
`default_nettype none

package efpga_pkg;

   localparam int DATA_W      = 32;  // bus data and memory write data
   localparam int BE_W        = 4;
   localparam int REG_ADR_W   = 2;   // wishbone word address
   localparam int TCDM_ADDR_W = 32;
   localparam int OFFSET_W    = 20;  // part of the address the fabric supplies
   localparam int PREFIX_W    = TCDM_ADDR_W - OFFSET_W;
   localparam int PORT_W      = 2;   // port select field of a command word
   localparam int EVT_MASK_W  = 8;
   localparam int CMD_RSVD_W  = DATA_W - PORT_W - 1 - BE_W - OFFSET_W;

   localparam logic [PREFIX_W-1:0] TCDM_PREFIX = 12'h1C0;  // fixed upper address bits

   localparam logic [REG_ADR_W-1:0] REG_DATA   = 2'd0;
   localparam logic [REG_ADR_W-1:0] REG_CMD    = 2'd1;
   localparam logic [REG_ADR_W-1:0] REG_EVENT  = 2'd2;
   localparam logic [REG_ADR_W-1:0] REG_STATUS = 2'd3;

   // one written word, decoded as a memory command or as an event mask
   typedef union packed {
      struct packed {
         logic [PORT_W-1:0]     port;
         logic                  wen;
         logic [BE_W-1:0]       be;
         logic [CMD_RSVD_W-1:0] rsvd;
         logic [OFFSET_W-1:0]   offset;
      } tcdm;
      struct packed {
         logic [DATA_W-EVT_MASK_W-1:0] rsvd;
         logic [EVT_MASK_W-1:0]        mask;
      } evt;
   } cmd_word_u;

endpackage

`default_nettype wire

/* hdl/cfg_bus_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_bus_bridge #(
   parameter int GNT_DELAY = 4
) (
   input  wire                              asic_clk_i,
   input  wire                              rst_n,
   input  wire                              enable_apb_i,
   input  wire                              wb_cyc_i,
   input  wire                              wb_stb_i,
   input  wire                              wb_we_i,
   input  wire  [efpga_pkg::REG_ADR_W-1:0]  wb_adr_i,
   input  wire  [efpga_pkg::DATA_W-1:0]     wb_dat_i,
   input  wire  [efpga_pkg::BE_W-1:0]       wb_sel_i,
   input  wire  [efpga_pkg::DATA_W-1:0]     reg_rdata_i,
   output logic                             wb_ack_o,
   output logic [efpga_pkg::DATA_W-1:0]     wb_dat_o,
   output logic                             reg_req_o,
   output logic                             reg_we_o,
   output logic [efpga_pkg::REG_ADR_W-1:0]  reg_adr_o,
   output logic [efpga_pkg::DATA_W-1:0]     reg_wdata_o
);

   logic                         access;    // bus cycle open toward us
   logic [GNT_DELAY-1:0]         gnt_sr_q;  // thermometer of cycles since stb
   logic [efpga_pkg::DATA_W-1:0] rdata_q;
   logic [efpga_pkg::DATA_W-1:0] sel_mask;

   assign access = wb_cyc_i & wb_stb_i;

   // byte lanes not selected are written as zero
   always_comb begin
      for (int i = 0; i < efpga_pkg::BE_W; i++) begin
         sel_mask[8*i +: 8] = {8{wb_sel_i[i]}};
      end
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         gnt_sr_q <= '0;
      end else if (!(access && enable_apb_i)) begin
         gnt_sr_q <= '0;  // restarts with the next stb
      end else begin
         gnt_sr_q <= {gnt_sr_q[GNT_DELAY-2:0], 1'b1};
      end
   end

   // register block answers one cycle after the access pulse
   always_ff @(posedge asic_clk_i) begin
      if (gnt_sr_q[0] && !gnt_sr_q[1]) begin
         rdata_q <= reg_rdata_i;
      end
   end

   // single pulse in the first stb cycle, only toward an enabled fabric
   assign reg_req_o   = enable_apb_i & access & (gnt_sr_q == '0);
   assign reg_we_o    = wb_we_i;
   assign reg_adr_o   = wb_adr_i;
   assign reg_wdata_o = wb_dat_i & sel_mask;

   // disabled fabric completes at once with zero data
   assign wb_ack_o = enable_apb_i ? (access & gnt_sr_q[GNT_DELAY-1]) : access;
   assign wb_dat_o = enable_apb_i ? rdata_q : '0;

   ack_one_cycle: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      wb_ack_o |=> !wb_ack_o);

   // enabled ack closes a strobe that has been held for the whole delay
   ack_after_delay: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      enable_apb_i && wb_ack_o |-> wb_stb_i && $past(wb_stb_i, GNT_DELAY));

endmodule

`default_nettype wire

/* hdl/fabric_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_regs #(
   parameter int N_TCDM_PORTS = 4,
   parameter int N_EVENTS     = 8
) (
   input  wire                              asic_clk_i,
   input  wire                              rst_n,
   input  wire                              reg_req_i,
   input  wire                              reg_we_i,
   input  wire  [efpga_pkg::REG_ADR_W-1:0]  reg_adr_i,
   input  wire  [efpga_pkg::DATA_W-1:0]     reg_wdata_i,
   input  wire  [N_TCDM_PORTS-1:0]          pending_i,
   output logic [efpga_pkg::DATA_W-1:0]     reg_rdata_o,
   output logic                             cmd_launch_o,
   output logic [efpga_pkg::PORT_W-1:0]     cmd_port_o,
   output logic                             cmd_wen_o,
   output logic [efpga_pkg::BE_W-1:0]       cmd_be_o,
   output logic [efpga_pkg::OFFSET_W-1:0]   cmd_offset_o,
   output logic [efpga_pkg::DATA_W-1:0]     cmd_data_o,
   output logic [N_EVENTS-1:0]              event_raise_o
);

   efpga_pkg::cmd_word_u         wr_word;   // incoming word, both views
   efpga_pkg::cmd_word_u         cmd_q;     // last command word
   logic [efpga_pkg::DATA_W-1:0] data_q;    // write data for memory commands
   logic [efpga_pkg::DATA_W-1:0] rd_mux;
   logic                         wr_data;
   logic                         wr_cmd;
   logic                         wr_evt;

   assign wr_word = reg_wdata_i;

   assign wr_data = reg_req_i & reg_we_i & (reg_adr_i == efpga_pkg::REG_DATA);
   assign wr_cmd  = reg_req_i & reg_we_i & (reg_adr_i == efpga_pkg::REG_CMD);
   assign wr_evt  = reg_req_i & reg_we_i & (reg_adr_i == efpga_pkg::REG_EVENT);

   always_comb begin
      case (reg_adr_i)
         efpga_pkg::REG_DATA:  rd_mux = data_q;
         efpga_pkg::REG_CMD:   rd_mux = cmd_q;
         efpga_pkg::REG_EVENT: rd_mux = '0;  // raise only, nothing stored
         default: begin
            rd_mux = {{(efpga_pkg::DATA_W-N_TCDM_PORTS){1'b0}}, pending_i};
         end
      endcase
   end

   always_ff @(posedge asic_clk_i) begin
      if (wr_data) begin
         data_q <= reg_wdata_i;
      end
      if (wr_cmd) begin
         cmd_q <= wr_word;
      end
      if (reg_req_i) begin
         reg_rdata_o <= rd_mux;  // ready one cycle after the access
      end
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         cmd_launch_o  <= 1'b0;
         event_raise_o <= '0;
      end else begin
         cmd_launch_o  <= wr_cmd;
         event_raise_o <= wr_evt ? wr_word.evt.mask[N_EVENTS-1:0] : '0;
      end
   end

   // command fields come from the stored word, valid with the launch
   assign cmd_port_o   = cmd_q.tcdm.port;
   assign cmd_wen_o    = cmd_q.tcdm.wen;
   assign cmd_be_o     = cmd_q.tcdm.be;
   assign cmd_offset_o = cmd_q.tcdm.offset;
   assign cmd_data_o   = data_q;

   launch_or_raise: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      cmd_launch_o |-> (event_raise_o == '0));

endmodule

`default_nettype wire

/* hdl/event_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module event_sync #(
   parameter int N_EVENTS = 8
) (
   input  wire                 asic_clk_i,
   input  wire                 rst_n,
   input  wire                 enable_events_i,
   input  wire  [N_EVENTS-1:0] event_raise_i,
   output logic [N_EVENTS-1:0] efpga_event_o
);

   logic [N_EVENTS-1:0] raise_gated;
   logic [N_EVENTS-1:0] pend_q;    // first stage, set by a raise
   logic [N_EVENTS-1:0] pend_d_q;  // second stage for edge detect

   // raises while events are off are simply dropped
   assign raise_gated = event_raise_i & {N_EVENTS{enable_events_i}};

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         pend_q   <= '0;
         pend_d_q <= '0;
      end else begin
         pend_q   <= (pend_q | raise_gated) & ~efpga_event_o;  // issued pulse clears
         pend_d_q <= pend_q;
      end
   end

   // rising edge of the pending flag, one cycle wide
   assign efpga_event_o = pend_q & ~pend_d_q;

   // every pulse goes back to an enabled raise one cycle earlier
   pulse_has_raise: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      (efpga_event_o & ~$past(event_raise_i & {N_EVENTS{enable_events_i}})) == '0);

endmodule

`default_nettype wire

/* hdl/tcdm_gate.sv */
`timescale 1ns/1ps
`default_nettype none

module tcdm_gate #(
   parameter int N_TCDM_PORTS = 4
) (
   input  wire                                asic_clk_i,
   input  wire                                rst_n,
   input  wire  [N_TCDM_PORTS-1:0]            enable_tcdm_i,
   input  wire                                cmd_launch_i,
   input  wire  [efpga_pkg::PORT_W-1:0]       cmd_port_i,
   input  wire                                cmd_wen_i,
   input  wire  [efpga_pkg::BE_W-1:0]         cmd_be_i,
   input  wire  [efpga_pkg::OFFSET_W-1:0]     cmd_offset_i,
   input  wire  [efpga_pkg::DATA_W-1:0]       cmd_data_i,
   input  wire  [N_TCDM_PORTS-1:0]            tcdm_gnt_i,
   output logic [N_TCDM_PORTS-1:0]            tcdm_req_o,
   output logic [N_TCDM_PORTS-1:0][efpga_pkg::TCDM_ADDR_W-1:0] tcdm_addr_o,
   output logic [N_TCDM_PORTS-1:0]            tcdm_wen_o,
   output logic [N_TCDM_PORTS-1:0][efpga_pkg::DATA_W-1:0]      tcdm_wdata_o,
   output logic [N_TCDM_PORTS-1:0][efpga_pkg::BE_W-1:0]        tcdm_be_o,
   output logic [N_TCDM_PORTS-1:0]            pending_o
);

   logic [N_TCDM_PORTS-1:0]                         pend_q;
   logic [N_TCDM_PORTS-1:0]                         take;  // command accepted into slot
   logic [N_TCDM_PORTS-1:0][efpga_pkg::OFFSET_W-1:0] offset_q;

   always_comb begin
      for (int p = 0; p < N_TCDM_PORTS; p++) begin
         // a busy slot ignores new commands
         take[p] = cmd_launch_i && (cmd_port_i == efpga_pkg::PORT_W'(p)) && !pend_q[p];
         tcdm_addr_o[p] = {efpga_pkg::TCDM_PREFIX, offset_q[p]};
      end
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         pend_q <= '0;
      end else begin
         pend_q <= (pend_q | take) & ~(tcdm_req_o & tcdm_gnt_i);  // done on req and gnt
      end
   end

   always_ff @(posedge asic_clk_i) begin
      for (int p = 0; p < N_TCDM_PORTS; p++) begin
         if (take[p]) begin
            offset_q[p]     <= cmd_offset_i;
            tcdm_wen_o[p]   <= cmd_wen_i;
            tcdm_wdata_o[p] <= cmd_data_i;
            tcdm_be_o[p]    <= cmd_be_i;
         end
      end
   end

   assign tcdm_req_o = pend_q & enable_tcdm_i;  // disabled port waits with req low
   assign pending_o  = pend_q;

   for (genvar g = 0; g < N_TCDM_PORTS; g++) begin : g_chk
      fields_stable: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
         tcdm_req_o[g] && !tcdm_gnt_i[g] |=> $stable(tcdm_addr_o[g])
            && $stable(tcdm_wdata_o[g]) && $stable(tcdm_be_o[g])
            && $stable(tcdm_wen_o[g]));
   end

endmodule

`default_nettype wire

/* hdl/efpga_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module efpga_subsystem #(
   parameter int N_TCDM_PORTS = 4,
   parameter int N_EVENTS     = 8,
   parameter int GNT_DELAY    = 4
) (
   input  wire                                  asic_clk_i,
   input  wire                                  rst_n,
   input  wire                                  enable_apb_i,
   input  wire                                  enable_events_i,
   input  wire  [N_TCDM_PORTS-1:0]              enable_tcdm_i,
   input  wire                                  wb_cyc_i,
   input  wire                                  wb_stb_i,
   input  wire                                  wb_we_i,
   input  wire  [efpga_pkg::REG_ADR_W-1:0]      wb_adr_i,
   input  wire  [efpga_pkg::DATA_W-1:0]         wb_dat_i,
   input  wire  [efpga_pkg::BE_W-1:0]           wb_sel_i,
   output logic                                 wb_ack_o,
   output logic [efpga_pkg::DATA_W-1:0]         wb_dat_o,
   output logic [N_TCDM_PORTS-1:0]              tcdm_req_o,
   output logic [N_TCDM_PORTS-1:0][efpga_pkg::TCDM_ADDR_W-1:0] tcdm_addr_o,
   output logic [N_TCDM_PORTS-1:0]              tcdm_wen_o,
   output logic [N_TCDM_PORTS-1:0][efpga_pkg::DATA_W-1:0]      tcdm_wdata_o,
   output logic [N_TCDM_PORTS-1:0][efpga_pkg::BE_W-1:0]        tcdm_be_o,
   input  wire  [N_TCDM_PORTS-1:0]              tcdm_gnt_i,
   output logic [N_EVENTS-1:0]                  efpga_event_o
);

   logic                             reg_req;
   logic                             reg_we;
   logic [efpga_pkg::REG_ADR_W-1:0]  reg_adr;
   logic [efpga_pkg::DATA_W-1:0]     reg_wdata;
   logic [efpga_pkg::DATA_W-1:0]     reg_rdata;
   logic                             cmd_launch;
   logic [efpga_pkg::PORT_W-1:0]     cmd_port;
   logic                             cmd_wen;
   logic [efpga_pkg::BE_W-1:0]       cmd_be;
   logic [efpga_pkg::OFFSET_W-1:0]   cmd_offset;
   logic [efpga_pkg::DATA_W-1:0]     cmd_data;
   logic [N_EVENTS-1:0]              event_raise;
   logic [N_TCDM_PORTS-1:0]          pending;     // per-port slots, shown at REG_STATUS

   cfg_bus_bridge #(
      .GNT_DELAY (GNT_DELAY)
   ) u_bridge (
      .asic_clk_i   (asic_clk_i),
      .rst_n        (rst_n),
      .enable_apb_i (enable_apb_i),
      .wb_cyc_i     (wb_cyc_i),
      .wb_stb_i     (wb_stb_i),
      .wb_we_i      (wb_we_i),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_sel_i     (wb_sel_i),
      .reg_rdata_i  (reg_rdata),
      .wb_ack_o     (wb_ack_o),
      .wb_dat_o     (wb_dat_o),
      .reg_req_o    (reg_req),
      .reg_we_o     (reg_we),
      .reg_adr_o    (reg_adr),
      .reg_wdata_o  (reg_wdata)
   );

   fabric_regs #(
      .N_TCDM_PORTS (N_TCDM_PORTS),
      .N_EVENTS     (N_EVENTS)
   ) u_regs (
      .asic_clk_i    (asic_clk_i),
      .rst_n         (rst_n),
      .reg_req_i     (reg_req),
      .reg_we_i      (reg_we),
      .reg_adr_i     (reg_adr),
      .reg_wdata_i   (reg_wdata),
      .pending_i     (pending),
      .reg_rdata_o   (reg_rdata),
      .cmd_launch_o  (cmd_launch),
      .cmd_port_o    (cmd_port),
      .cmd_wen_o     (cmd_wen),
      .cmd_be_o      (cmd_be),
      .cmd_offset_o  (cmd_offset),
      .cmd_data_o    (cmd_data),
      .event_raise_o (event_raise)
   );

   event_sync #(
      .N_EVENTS (N_EVENTS)
   ) u_events (
      .asic_clk_i      (asic_clk_i),
      .rst_n           (rst_n),
      .enable_events_i (enable_events_i),
      .event_raise_i   (event_raise),
      .efpga_event_o   (efpga_event_o)
   );

   tcdm_gate #(
      .N_TCDM_PORTS (N_TCDM_PORTS)
   ) u_tcdm (
      .asic_clk_i    (asic_clk_i),
      .rst_n         (rst_n),
      .enable_tcdm_i (enable_tcdm_i),
      .cmd_launch_i  (cmd_launch),
      .cmd_port_i    (cmd_port),
      .cmd_wen_i     (cmd_wen),
      .cmd_be_i      (cmd_be),
      .cmd_offset_i  (cmd_offset),
      .cmd_data_i    (cmd_data),
      .tcdm_gnt_i    (tcdm_gnt_i),
      .tcdm_req_o    (tcdm_req_o),
      .tcdm_addr_o   (tcdm_addr_o),
      .tcdm_wen_o    (tcdm_wen_o),
      .tcdm_wdata_o  (tcdm_wdata_o),
      .tcdm_be_o     (tcdm_be_o),
      .pending_o     (pending)
   );

endmodule

`default_nettype wire

/* test/efpga_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module efpga_checker #(
   parameter int N_TCDM_PORTS = 4,
   parameter int N_EVENTS     = 8,
   parameter int GNT_DELAY    = 4,
   parameter int LIMIT        = 1000
) (
   input  wire                               clk_i,
   input  wire                               rst_n,
   input  wire                               en_apb_i,
   input  wire                               cyc_i,
   input  wire                               stb_i,
   input  wire                               ack_i,
   input  wire  [31:0]                       dat_i,
   input  wire  [N_TCDM_PORTS-1:0]           req_i,
   input  wire  [N_TCDM_PORTS-1:0]           gnt_i,
   input  wire  [N_TCDM_PORTS-1:0][31:0]     addr_i,
   input  wire  [N_TCDM_PORTS-1:0][31:0]     wdata_i,
   input  wire  [N_TCDM_PORTS-1:0][3:0]      be_i,
   input  wire  [N_TCDM_PORTS-1:0]           wen_i,
   input  wire  [N_EVENTS-1:0]               events_i,
   input  wire                               cmp_i,
   input  wire                               chk_rd_i,
   input  wire  [31:0]                       exp_rd_i,
   input  wire  [N_EVENTS-1:0]               exp_ev_i,
   input  wire  [N_TCDM_PORTS-1:0]           exp_gnt_i,
   input  wire  [31:0]                       exp_addr_i,
   input  wire  [31:0]                       exp_wdata_i,
   input  wire  [3:0]                        exp_be_i,
   input  wire                               exp_wen_i,
   output logic [31:0]                       value_errs_o,
   output logic [31:0]                       count_errs_o,
   output logic                              timed_out_o
);

   int          stb_cnt;               // cycles stb has waited for ack
   int          ev_cnt  [N_EVENTS];
   int          gnt_cnt [N_TCDM_PORTS];
   logic [31:0] last_addr;
   logic [31:0] last_wdata;
   logic [3:0]  last_be;
   logic        last_wen;
   int          cycles;

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
      value_errs_o = value_errs_o + 1;
   endtask

   initial begin
      value_errs_o = 0;
      count_errs_o = 0;
      timed_out_o  = 0;
      stb_cnt      = 0;
      cycles       = 0;
      foreach (ev_cnt[i]) ev_cnt[i] = 0;
      foreach (gnt_cnt[p]) gnt_cnt[p] = 0;
   end

   // sampled mid-cycle, all DUT outputs are settled here
   always @(negedge clk_i) begin
      if (rst_n) begin
         if (cyc_i && stb_i) begin
            if (ack_i) begin
               if (stb_cnt != (en_apb_i ? GNT_DELAY : 0)) begin
                  report_mismatch("ack latency", en_apb_i ? GNT_DELAY : 0, stb_cnt);
               end
               if (chk_rd_i && dat_i !== exp_rd_i) begin
                  report_mismatch("wb_dat_o", exp_rd_i, dat_i);
               end
               stb_cnt = 0;
            end else begin
               stb_cnt = stb_cnt + 1;
            end
         end else begin
            stb_cnt = 0;
         end
         for (int i = 0; i < N_EVENTS; i++) begin
            if (events_i[i]) ev_cnt[i] = ev_cnt[i] + 1;
         end
         for (int p = 0; p < N_TCDM_PORTS; p++) begin
            if (req_i[p] && gnt_i[p]) begin
               gnt_cnt[p] = gnt_cnt[p] + 1;
               last_addr  = addr_i[p];
               last_wdata = wdata_i[p];
               last_be    = be_i[p];
               last_wen   = wen_i[p];
            end
         end
         if (cmp_i) begin
            for (int i = 0; i < N_EVENTS; i++) begin
               if (ev_cnt[i] != (exp_ev_i[i] ? 1 : 0)) begin
                  $display("FAILED %0t efpga_event_o[%0d] expected %0d actual %0d pulses",
                           $time, i, exp_ev_i[i], ev_cnt[i]);
                  count_errs_o = count_errs_o + 1;
               end
               ev_cnt[i] = 0;
            end
            for (int p = 0; p < N_TCDM_PORTS; p++) begin
               if (gnt_cnt[p] != (exp_gnt_i[p] ? 1 : 0)) begin
                  $display("FAILED %0t tcdm port %0d expected %0d actual %0d grants",
                           $time, p, exp_gnt_i[p], gnt_cnt[p]);
                  count_errs_o = count_errs_o + 1;
               end
               gnt_cnt[p] = 0;
            end
            if (exp_gnt_i != '0) begin
               if (last_addr !== exp_addr_i) report_mismatch("tcdm_addr_o", exp_addr_i, last_addr);
               if (last_wdata !== exp_wdata_i) begin
                  report_mismatch("tcdm_wdata_o", exp_wdata_i, last_wdata);
               end
               if (last_be !== exp_be_i) report_mismatch("tcdm_be_o", exp_be_i, last_be);
               if (last_wen !== exp_wen_i) report_mismatch("tcdm_wen_o", exp_wen_i, last_wen);
            end
         end
      end
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles == LIMIT && !timed_out_o) begin
         $display("timeout: run did not finish within %0d cycles", LIMIT);
         timed_out_o <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* test/tb_efpga_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_efpga_subsystem;

   localparam int N_PORTS = 4;
   localparam int N_EV    = 8;
   localparam int GNT_DLY = 4;
   localparam int N_ROWS  = 12;
   localparam int LIMIT   = N_ROWS * 32 + 100 + 8;  // rows, slack and reset

   typedef struct packed {
      logic        apb;
      logic        evt;
      logic [3:0]  tcdm;
      logic        we;
      logic [1:0]  adr;
      logic [31:0] dat;
      logic        chk_rd;     // compare read data at ack
      logic [31:0] exp_rd;
      logic [7:0]  exp_ev;     // lines expected to pulse once
      logic [3:0]  exp_gnt;    // ports expected to complete once
      logic [31:0] exp_addr;
      logic [31:0] exp_wdata;
      logic [3:0]  exp_be;
      logic        exp_wen;
   } row_t;

   logic                         clk;
   logic                         rst_n;
   logic                         en_apb;
   logic                         en_evt;
   logic [N_PORTS-1:0]           en_tcdm;
   logic                         cyc;
   logic                         stb;
   logic                         we;
   logic [1:0]                   adr;
   logic [31:0]                  dat;
   logic [3:0]                   sel;
   wire                          ack;
   wire  [31:0]                  dat_o;
   wire  [N_PORTS-1:0]           req;
   wire  [N_PORTS-1:0][31:0]     addr;
   wire  [N_PORTS-1:0]           wen;
   wire  [N_PORTS-1:0][31:0]     wdata;
   wire  [N_PORTS-1:0][3:0]      be;
   logic [N_PORTS-1:0]           gnt;
   wire  [N_EV-1:0]              events;
   logic                         cmp;
   wire  [31:0]                  value_errs;
   wire  [31:0]                  count_errs;
   wire                          timed_out;
   row_t                         rows [N_ROWS];
   row_t                         cur;
   logic [N_PORTS-1:0]           busy;
   int unsigned                  wait_cnt [N_PORTS];

   efpga_subsystem #(
      .N_TCDM_PORTS (N_PORTS),
      .N_EVENTS     (N_EV),
      .GNT_DELAY    (GNT_DLY)
   ) dut (
      .asic_clk_i      (clk),
      .rst_n           (rst_n),
      .enable_apb_i    (en_apb),
      .enable_events_i (en_evt),
      .enable_tcdm_i   (en_tcdm),
      .wb_cyc_i        (cyc),
      .wb_stb_i        (stb),
      .wb_we_i         (we),
      .wb_adr_i        (adr),
      .wb_dat_i        (dat),
      .wb_sel_i        (sel),
      .wb_ack_o        (ack),
      .wb_dat_o        (dat_o),
      .tcdm_req_o      (req),
      .tcdm_addr_o     (addr),
      .tcdm_wen_o      (wen),
      .tcdm_wdata_o    (wdata),
      .tcdm_be_o       (be),
      .tcdm_gnt_i      (gnt),
      .efpga_event_o   (events)
   );

   efpga_checker #(
      .N_TCDM_PORTS (N_PORTS),
      .N_EVENTS     (N_EV),
      .GNT_DELAY    (GNT_DLY),
      .LIMIT        (LIMIT)
   ) chk (
      .clk_i       (clk),
      .rst_n       (rst_n),
      .en_apb_i    (en_apb),
      .cyc_i       (cyc),
      .stb_i       (stb),
      .ack_i       (ack),
      .dat_i       (dat_o),
      .req_i       (req),
      .gnt_i       (gnt),
      .addr_i      (addr),
      .wdata_i     (wdata),
      .be_i        (be),
      .wen_i       (wen),
      .events_i    (events),
      .cmp_i       (cmp),
      .chk_rd_i    (cur.chk_rd),
      .exp_rd_i    (cur.exp_rd),
      .exp_ev_i    (cur.exp_ev),
      .exp_gnt_i   (cur.exp_gnt),
      .exp_addr_i  (cur.exp_addr),
      .exp_wdata_i (cur.exp_wdata),
      .exp_be_i    (cur.exp_be),
      .exp_wen_i   (cur.exp_wen),
      .value_errs_o(value_errs),
      .count_errs_o(count_errs),
      .timed_out_o (timed_out)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] tcdm_cmd(input logic [1:0] port, input logic w,
                                            input logic [3:0] b, input logic [19:0] off);
      efpga_pkg::cmd_word_u word;
      word             = '0;
      word.tcdm.port   = port;
      word.tcdm.wen    = w;
      word.tcdm.be     = b;
      word.tcdm.offset = off;
      return word;
   endfunction

   function automatic logic [31:0] event_cmd(input logic [7:0] mask);
      efpga_pkg::cmd_word_u word;
      word          = '0;
      word.evt.mask = mask;
      return word;
   endfunction

   task automatic run_row(input row_t r);
      @(posedge clk);
      #0.5;
      cur     = r;
      en_apb  = r.apb;
      en_evt  = r.evt;
      en_tcdm = r.tcdm;
      cyc     = 1'b1;
      stb     = 1'b1;
      we      = r.we;
      adr     = r.adr;
      dat     = r.dat;
      do begin
         @(negedge clk);
      end while (!ack);
      @(posedge clk);
      #0.5;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      repeat (10) @(posedge clk);
      #0.5;
      cmp = 1'b1;
      @(posedge clk);
      #0.5;
      cmp = 1'b0;
   endtask

   // memory side answers each request after 0 to 3 cycles
   always @(posedge clk) begin
      #0.5;
      for (int p = 0; p < N_PORTS; p++) begin
         if (gnt[p]) begin
            gnt[p]  = 1'b0;
            busy[p] = 1'b0;
         end else if (busy[p]) begin
            wait_cnt[p] = wait_cnt[p] - 1;
            gnt[p]      = (wait_cnt[p] == 0);
         end else if (req[p]) begin
            busy[p]     = 1'b1;
            wait_cnt[p] = $urandom % 4;
            gnt[p]      = (wait_cnt[p] == 0);
         end
      end
   end

   always @(posedge timed_out) begin
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      void'($urandom(32'h4657));
      clk     = 0;
      rst_n   = 0;
      en_apb  = 0;
      en_evt  = 0;
      en_tcdm = '0;
      cyc     = 0;
      stb     = 0;
      we      = 0;
      adr     = '0;
      dat     = '0;
      sel     = 4'hF;
      gnt     = '0;
      busy    = '0;
      cmp     = 0;
      cur     = '0;
      foreach (wait_cnt[p]) wait_cnt[p] = 0;
      //          apb evt tcdm  we adr dat  chk rd  ev gnt addr wdata be wen
      rows[0]  = '{1, 1, 4'hF, 1, 0, 32'hA5A51234, 0, 0, 0, 0, 0, 0, 0, 0};
      rows[1]  = '{1, 1, 4'hF, 0, 0, 0, 1, 32'hA5A51234, 0, 0, 0, 0, 0, 0};
      rows[2]  = '{0, 1, 4'hF, 1, 0, 32'h0000DEAD, 0, 0, 0, 0, 0, 0, 0, 0};
      rows[3]  = '{0, 1, 4'hF, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0};
      rows[4]  = '{1, 1, 4'hF, 0, 0, 0, 1, 32'hA5A51234, 0, 0, 0, 0, 0, 0};
      rows[5]  = '{1, 1, 4'hF, 1, 1, tcdm_cmd(2'd1, 1'b1, 4'h3, 20'h12345), 0, 0, 0,
                   4'b0010, 32'h1C012345, 32'hA5A51234, 4'h3, 1};
      rows[6]  = '{1, 1, 4'hB, 1, 1, tcdm_cmd(2'd2, 1'b0, 4'hF, 20'hABCDE), 0, 0, 0,
                   0, 0, 0, 0, 0};
      rows[7]  = '{1, 1, 4'hB, 0, 3, 0, 1, 32'h4, 0, 0, 0, 0, 0, 0};
      rows[8]  = '{1, 1, 4'hF, 0, 0, 0, 1, 32'hA5A51234, 0,
                   4'b0100, 32'h1C0ABCDE, 32'hA5A51234, 4'hF, 0};
      rows[9]  = '{1, 1, 4'hF, 0, 3, 0, 1, 0, 0, 0, 0, 0, 0, 0};
      rows[10] = '{1, 1, 4'hF, 1, 2, event_cmd(8'h5A), 0, 0, 8'h5A, 0, 0, 0, 0, 0};
      rows[11] = '{1, 0, 4'hF, 1, 2, event_cmd(8'hFF), 0, 0, 0, 0, 0, 0, 0, 0};
      repeat (8) @(posedge clk);
      #0.5;
      rst_n = 1;
      for (int i = 0; i < N_ROWS; i++) begin
         run_row(rows[i]);
      end
      repeat (2) @(posedge clk);
      $display("errors: %0d value, %0d count", value_errs, count_errs);
      if (value_errs == 0 && count_errs == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* efpga_subsystem.f */
hdl/efpga_pkg.sv
hdl/cfg_bus_bridge.sv
hdl/fabric_regs.sv
hdl/event_sync.sv
hdl/tcdm_gate.sv
hdl/efpga_subsystem.sv
test/efpga_checker.sv
test/tb_efpga_subsystem.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_efpga_subsystem \
   -f efpga_subsystem.f \
   -o sim_efpga

./obj_dir/sim_efpga > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
   exit 0
fi
exit 1
